//--- src/dma_pkg.sv
package dma_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [15:0] xsize_t;
    typedef logic [2:0]  reg_idx_t;

    // register map
    localparam reg_idx_t REG_CMD      = 3'd0;
    localparam reg_idx_t REG_STATUS   = 3'd1;
    localparam reg_idx_t REG_INTREN   = 3'd2;
    localparam reg_idx_t REG_SRCADDR  = 3'd3;
    localparam reg_idx_t REG_DESADDR  = 3'd4;
    localparam reg_idx_t REG_XSIZE    = 3'd5;
    localparam reg_idx_t REG_LINKADDR = 3'd6;

    localparam int CMD_EN_BIT    = 0;
    localparam int STAT_DONE_BIT = 0;
    localparam int STAT_ERR_BIT  = 1; // intren uses the same positions
    localparam int LINK_EN_BIT   = 0;

    localparam addr_t WORD_BYTES = 32'd4;
    localparam int    LINK_WORDS = 4; // src, dst, size, next link
    localparam int    LINK_CNT_W = $clog2(LINK_WORDS);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        addr_t  src;
        addr_t  dst;
        xsize_t size;
    } desc_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic  valid;
        data_t data;
        logic  err;   // resp was not OKAY
    } rd_rsp_t;

endpackage

//--- src/dma_chan_regs.sv
`timescale 1ns/10ps

module dma_chan_regs import dma_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     reg_wr_i,
    input  reg_idx_t reg_idx_i,
    input  data_t    reg_wdata_i,
    input  logic     copy_done_i,
    input  logic     copy_err_i,
    input  logic     fetch_done_i,
    input  desc_t    fetch_desc_i,
    input  data_t    fetch_link_i,
    input  logic     fetch_err_i,
    output data_t    reg_rdata_o,
    output logic     irq_o,
    output logic     copy_start_o,
    output desc_t    copy_desc_o,
    output logic     fetch_start_o,
    output addr_t    fetch_addr_o
);

    logic       cmd_en_q;
    logic [1:0] status_q;
    logic [1:0] status_nxt;
    logic [1:0] intren_q;
    addr_t      src_q;
    addr_t      dst_q;
    xsize_t     xsize_q;
    data_t      link_q;
    logic       link_en;
    logic       start_wr;
    logic       chain_end;
    logic       any_err;

    assign link_en   = link_q[LINK_EN_BIT];
    assign start_wr  = reg_wr_i && (reg_idx_i == REG_CMD) && reg_wdata_i[CMD_EN_BIT] && !cmd_en_q;
    assign chain_end = copy_done_i && !link_en; // last descriptor finished
    assign any_err   = copy_err_i || fetch_err_i;

    assign copy_desc_o.src  = src_q;
    assign copy_desc_o.dst  = dst_q;
    assign copy_desc_o.size = xsize_q;
    assign fetch_addr_o     = {link_q[31:2], 2'b00};

    always_comb begin
        status_nxt = status_q;
        if (reg_wr_i && (reg_idx_i == REG_STATUS))
            status_nxt = status_q & ~reg_wdata_i[1:0]; // w1c
        // hardware events win over a clear in the same cycle
        if (chain_end)
            status_nxt[STAT_DONE_BIT] = 1'b1;
        if (any_err)
            status_nxt[STAT_ERR_BIT] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cmd_en_q      <= 1'b0;
            status_q      <= '0;
            intren_q      <= '0;
            link_q        <= '0;
            copy_start_o  <= 1'b0;
            fetch_start_o <= 1'b0;
            irq_o         <= 1'b0;
        end else begin
            status_q      <= status_nxt;
            irq_o         <= |(status_q & intren_q);
            copy_start_o  <= start_wr || fetch_done_i;
            fetch_start_o <= copy_done_i && link_en;
            if (start_wr)
                cmd_en_q <= 1'b1;
            else if (chain_end || any_err)
                cmd_en_q <= 1'b0;
            if (reg_wr_i && (reg_idx_i == REG_INTREN))
                intren_q <= reg_wdata_i[1:0];
            if (fetch_done_i)
                link_q <= fetch_link_i;    // next hop from memory
            else if (reg_wr_i && (reg_idx_i == REG_LINKADDR))
                link_q <= reg_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done_i) begin
            src_q   <= fetch_desc_i.src;
            dst_q   <= fetch_desc_i.dst;
            xsize_q <= fetch_desc_i.size;
        end else if (reg_wr_i) begin
            case (reg_idx_i)
                REG_SRCADDR: src_q   <= reg_wdata_i;
                REG_DESADDR: dst_q   <= reg_wdata_i;
                REG_XSIZE:   xsize_q <= reg_wdata_i[15:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        reg_rdata_o = '0;
        case (reg_idx_i)
            REG_CMD:      reg_rdata_o[CMD_EN_BIT] = cmd_en_q;
            REG_STATUS:   reg_rdata_o[1:0] = status_q;
            REG_INTREN:   reg_rdata_o[1:0] = intren_q;
            REG_SRCADDR:  reg_rdata_o = src_q;
            REG_DESADDR:  reg_rdata_o = dst_q;
            REG_XSIZE:    reg_rdata_o[15:0] = xsize_q;
            REG_LINKADDR: reg_rdata_o = link_q;
            default: ;
        endcase
    end

    // copy and link fetch never start together
    a_start_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(copy_start_o && fetch_start_o));

endmodule

//--- src/dma_link_fetch.sv
`timescale 1ns/10ps

module dma_link_fetch import dma_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    fetch_start_i,
    input  addr_t   fetch_addr_i,
    input  logic    rd_ready_i,
    input  rd_rsp_t rd_rsp_i,
    output rd_req_t rd_req_o,
    output logic    fetch_done_o,
    output desc_t   fetch_desc_o,
    output data_t   fetch_link_o,
    output logic    fetch_err_o
);

    typedef enum logic [1:0] {IDLE, REQ, WAIT} state_t;

    state_t                state_q;
    logic [LINK_CNT_W-1:0] cnt_q;
    addr_t                 addr_q;
    logic                  beat_ok;

    assign rd_req_o.valid = (state_q == REQ);
    assign rd_req_o.addr  = addr_q;
    assign beat_ok        = (state_q == WAIT) && rd_rsp_i.valid && !rd_rsp_i.err;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            cnt_q        <= '0;
            fetch_done_o <= 1'b0;
            fetch_err_o  <= 1'b0;
        end else begin
            fetch_done_o <= 1'b0;
            fetch_err_o  <= 1'b0;
            case (state_q)
                IDLE: if (fetch_start_i) begin
                    cnt_q   <= '0;
                    state_q <= REQ;
                end
                REQ: if (rd_ready_i)
                    state_q <= WAIT;
                WAIT: if (rd_rsp_i.valid) begin
                    if (rd_rsp_i.err) begin
                        fetch_err_o <= 1'b1;   // abandon the descriptor
                        state_q     <= IDLE;
                    end else if (cnt_q == LINK_CNT_W'(LINK_WORDS - 1)) begin
                        fetch_done_o <= 1'b1;
                        state_q      <= IDLE;
                    end else begin
                        cnt_q   <= cnt_q + 1'b1;
                        state_q <= REQ;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && fetch_start_i)
            addr_q <= fetch_addr_i;
        else if (beat_ok)
            addr_q <= addr_q + WORD_BYTES;
        if (beat_ok) begin
            case (cnt_q)
                LINK_CNT_W'(0): fetch_desc_o.src  <= rd_rsp_i.data;
                LINK_CNT_W'(1): fetch_desc_o.dst  <= rd_rsp_i.data;
                LINK_CNT_W'(2): fetch_desc_o.size <= rd_rsp_i.data[15:0];
                default:        fetch_link_o      <= rd_rsp_i.data;
            endcase
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_req_o.valid && !rd_ready_i |=> rd_req_o.valid && $stable(rd_req_o.addr));

endmodule

//--- src/dma_data_mover.sv
`timescale 1ns/10ps

module dma_data_mover import dma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       copy_start_i,
    input  desc_t      copy_desc_i,
    input  logic       rd_ready_i,
    input  rd_rsp_t    rd_rsp_i,
    input  logic       aw_ready_i,
    input  logic       w_ready_i,
    input  logic       b_valid_i,
    input  logic [1:0] b_resp_i,
    output rd_req_t    rd_req_o,
    output logic       aw_valid_o,
    output addr_t      aw_addr_o,
    output logic       w_valid_o,
    output data_t      w_data_o,
    output logic       b_ready_o,
    output logic       copy_done_o,
    output logic       copy_err_o
);

    typedef enum logic [2:0] {IDLE, RD_REQ, RD_WAIT, WR, WR_RESP} state_t;

    state_t state_q;
    addr_t  src_q;
    addr_t  dst_q;
    xsize_t left_q;    // words still to move
    data_t  data_q;
    logic   aw_pend_q;
    logic   w_pend_q;
    logic   start;
    logic   word_ok;

    assign start   = (state_q == IDLE) && copy_start_i;
    assign word_ok = (state_q == WR_RESP) && b_valid_i && (b_resp_i == RESP_OKAY);

    assign rd_req_o.valid = (state_q == RD_REQ);
    assign rd_req_o.addr  = src_q;
    assign aw_valid_o     = aw_pend_q;
    assign aw_addr_o      = dst_q;
    assign w_valid_o      = w_pend_q;
    assign w_data_o       = data_q;
    assign b_ready_o      = (state_q == WR_RESP);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            aw_pend_q   <= 1'b0;
            w_pend_q    <= 1'b0;
            copy_done_o <= 1'b0;
            copy_err_o  <= 1'b0;
        end else begin
            copy_done_o <= 1'b0;
            copy_err_o  <= 1'b0;
            case (state_q)
                IDLE: if (copy_start_i) begin
                    if (copy_desc_i.size == '0)
                        copy_done_o <= 1'b1;   // empty descriptor
                    else
                        state_q <= RD_REQ;
                end
                RD_REQ: if (rd_ready_i)
                    state_q <= RD_WAIT;
                RD_WAIT: if (rd_rsp_i.valid) begin
                    if (rd_rsp_i.err) begin
                        copy_err_o <= 1'b1;
                        state_q    <= IDLE;
                    end else begin
                        aw_pend_q <= 1'b1;     // aw and w offered together
                        w_pend_q  <= 1'b1;
                        state_q   <= WR;
                    end
                end
                WR: begin
                    if (aw_ready_i)
                        aw_pend_q <= 1'b0;
                    if (w_ready_i)
                        w_pend_q <= 1'b0;
                    if ((aw_ready_i || !aw_pend_q) && (w_ready_i || !w_pend_q))
                        state_q <= WR_RESP;
                end
                WR_RESP: if (b_valid_i) begin
                    if (b_resp_i != RESP_OKAY) begin
                        copy_err_o <= 1'b1;
                        state_q    <= IDLE;
                    end else if (left_q == xsize_t'(1)) begin
                        copy_done_o <= 1'b1;
                        state_q     <= IDLE;
                    end else begin
                        state_q <= RD_REQ;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            src_q  <= copy_desc_i.src;
            dst_q  <= copy_desc_i.dst;
            left_q <= copy_desc_i.size;
        end else if (word_ok) begin
            src_q  <= src_q + WORD_BYTES;
            dst_q  <= dst_q + WORD_BYTES;
            left_q <= left_q - 1'b1;
        end
        if ((state_q == RD_WAIT) && rd_rsp_i.valid)
            data_q <= rd_rsp_i.data;
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        aw_valid_o && !aw_ready_i |=> aw_valid_o);

endmodule

//--- src/dma_rd_arbiter.sv
`timescale 1ns/10ps

module dma_rd_arbiter import dma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  rd_req_t    fetch_req_i,
    input  rd_req_t    move_req_i,
    input  logic       ar_ready_i,
    input  logic       r_valid_i,
    input  data_t      r_data_i,
    input  logic [1:0] r_resp_i,
    output logic       fetch_ready_o,
    output logic       move_ready_o,
    output rd_rsp_t    fetch_rsp_o,
    output rd_rsp_t    move_rsp_o,
    output logic       ar_valid_o,
    output addr_t      ar_addr_o,
    output logic       r_ready_o
);

    logic busy_q;       // read outstanding
    logic gnt_fetch_q;  // owner of the outstanding read
    logic sel_fetch;
    logic r_err;

    assign sel_fetch = fetch_req_i.valid; // fetch wins
    assign ar_valid_o = !busy_q && (fetch_req_i.valid || move_req_i.valid);
    assign ar_addr_o  = sel_fetch ? fetch_req_i.addr : move_req_i.addr;
    assign fetch_ready_o = !busy_q && ar_ready_i && sel_fetch;
    assign move_ready_o  = !busy_q && ar_ready_i && !sel_fetch;
    assign r_ready_o = busy_q;
    assign r_err     = (r_resp_i != RESP_OKAY);

    assign fetch_rsp_o.valid = r_valid_i && busy_q && gnt_fetch_q;
    assign fetch_rsp_o.data  = r_data_i;
    assign fetch_rsp_o.err   = r_err;
    assign move_rsp_o.valid  = r_valid_i && busy_q && !gnt_fetch_q;
    assign move_rsp_o.data   = r_data_i;
    assign move_rsp_o.err    = r_err;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            gnt_fetch_q <= 1'b0;
        end else if (ar_valid_o && ar_ready_i) begin
            busy_q      <= 1'b1;
            gnt_fetch_q <= sel_fetch;
        end else if (r_valid_i && r_ready_o) begin
            busy_q <= 1'b0;
        end
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        ar_valid_o && ar_ready_i |=> !ar_valid_o);

endmodule

//--- src/dma_channel.sv
`timescale 1ns/10ps

module dma_channel import dma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       reg_wr_i,
    input  reg_idx_t   reg_idx_i,
    input  data_t      reg_wdata_i,
    input  logic       ar_ready_i,
    input  logic       r_valid_i,
    input  data_t      r_data_i,
    input  logic [1:0] r_resp_i,
    input  logic       aw_ready_i,
    input  logic       w_ready_i,
    input  logic       b_valid_i,
    input  logic [1:0] b_resp_i,
    output data_t      reg_rdata_o,
    output logic       irq_o,
    output logic       ar_valid_o,
    output addr_t      ar_addr_o,
    output logic       r_ready_o,
    output logic       aw_valid_o,
    output addr_t      aw_addr_o,
    output logic       w_valid_o,
    output data_t      w_data_o,
    output logic       b_ready_o
);

    logic    copy_start;
    desc_t   copy_desc;
    logic    copy_done;
    logic    copy_err;
    logic    fetch_start;
    addr_t   fetch_addr;
    logic    fetch_done;
    desc_t   fetch_desc;
    data_t   fetch_link;
    logic    fetch_err;
    rd_req_t fetch_req;
    rd_req_t move_req;
    logic    fetch_ready;
    logic    move_ready;
    rd_rsp_t fetch_rsp;
    rd_rsp_t move_rsp;

    dma_chan_regs u_regs (
        .clk(clk), .rst_n_i(rst_n_i),
        .reg_wr_i(reg_wr_i), .reg_idx_i(reg_idx_i), .reg_wdata_i(reg_wdata_i),
        .copy_done_i(copy_done), .copy_err_i(copy_err),
        .fetch_done_i(fetch_done), .fetch_desc_i(fetch_desc),
        .fetch_link_i(fetch_link), .fetch_err_i(fetch_err),
        .reg_rdata_o(reg_rdata_o), .irq_o(irq_o),
        .copy_start_o(copy_start), .copy_desc_o(copy_desc),
        .fetch_start_o(fetch_start), .fetch_addr_o(fetch_addr)
    );

    dma_link_fetch u_fetch (
        .clk(clk), .rst_n_i(rst_n_i),
        .fetch_start_i(fetch_start), .fetch_addr_i(fetch_addr),
        .rd_ready_i(fetch_ready), .rd_rsp_i(fetch_rsp), .rd_req_o(fetch_req),
        .fetch_done_o(fetch_done), .fetch_desc_o(fetch_desc),
        .fetch_link_o(fetch_link), .fetch_err_o(fetch_err)
    );

    dma_data_mover u_mover (
        .clk(clk), .rst_n_i(rst_n_i),
        .copy_start_i(copy_start), .copy_desc_i(copy_desc),
        .rd_ready_i(move_ready), .rd_rsp_i(move_rsp),
        .aw_ready_i(aw_ready_i), .w_ready_i(w_ready_i),
        .b_valid_i(b_valid_i), .b_resp_i(b_resp_i),
        .rd_req_o(move_req), .aw_valid_o(aw_valid_o), .aw_addr_o(aw_addr_o),
        .w_valid_o(w_valid_o), .w_data_o(w_data_o), .b_ready_o(b_ready_o),
        .copy_done_o(copy_done), .copy_err_o(copy_err)
    );

    dma_rd_arbiter u_rd_arb (
        .clk(clk), .rst_n_i(rst_n_i),
        .fetch_req_i(fetch_req), .move_req_i(move_req),
        .ar_ready_i(ar_ready_i), .r_valid_i(r_valid_i),
        .r_data_i(r_data_i), .r_resp_i(r_resp_i),
        .fetch_ready_o(fetch_ready), .move_ready_o(move_ready),
        .fetch_rsp_o(fetch_rsp), .move_rsp_o(move_rsp),
        .ar_valid_o(ar_valid_o), .ar_addr_o(ar_addr_o), .r_ready_o(r_ready_o)
    );

endmodule

//--- tests/dma_mem_model.sv
`timescale 1ns/10ps

module dma_mem_model import dma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       ar_valid_i,
    input  addr_t      ar_addr_i,
    output logic       ar_ready_o,
    output logic       r_valid_o,
    output data_t      r_data_o,
    output logic [1:0] r_resp_o,
    input  logic       r_ready_i,
    input  logic       aw_valid_i,
    output logic       aw_ready_o,
    input  logic       w_valid_i,
    output logic       w_ready_o,
    output logic       b_valid_o,
    output logic [1:0] b_resp_o,
    input  logic       b_ready_i
);

    localparam data_t PATTERN   = 32'h5a5a_0000;
    localparam addr_t ERR_BASE  = 32'h0000_f000;
    localparam addr_t ERR_LIMIT = 32'h0000_f100;  // reads in [base, limit) fail

    data_t      mem [addr_t];   // preloaded words override the pattern
    logic       rd_pend;
    addr_t      rd_addr;
    logic       aw_got;
    logic       w_got;
    logic [1:0] ar_wait;
    logic [1:0] r_wait;
    logic [1:0] aw_wait;
    logic [1:0] w_wait;
    logic [1:0] b_wait;

    assign b_resp_o = RESP_OKAY;

    function automatic data_t read_word(input addr_t a);
        if (mem.exists(a))
            return mem[a];
        return a ^ PATTERN;
    endfunction

    task automatic load_word(input addr_t a, input data_t d);
        mem[a] = d;
    endtask

    initial begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_resp_o   = RESP_OKAY;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            b_valid_o  <= 1'b0;
            rd_pend    <= 1'b0;
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            ar_wait    <= 2'd0;
            r_wait     <= 2'd0;
            aw_wait    <= 2'd0;
            w_wait     <= 2'd0;
            b_wait     <= 2'd0;
        end else begin
            // read address ready after a random stall
            if (ar_valid_i && !ar_ready_o && !rd_pend) begin
                if (ar_wait == 2'd0)
                    ar_ready_o <= 1'b1;
                else
                    ar_wait <= ar_wait - 2'd1;
            end
            if (ar_valid_i && ar_ready_o) begin
                ar_ready_o <= 1'b0;
                rd_pend    <= 1'b1;
                rd_addr    <= ar_addr_i;
                ar_wait    <= 2'($urandom_range(3, 0));
            end
            if (rd_pend && !r_valid_o) begin
                if (r_wait == 2'd0) begin
                    r_valid_o <= 1'b1;
                    r_data_o  <= read_word(rd_addr);
                    r_resp_o  <= (rd_addr >= ERR_BASE && rd_addr < ERR_LIMIT) ? 2'b10 : RESP_OKAY;
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
            if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                rd_pend   <= 1'b0;
                r_wait    <= 2'($urandom_range(3, 0));
            end
            // write address and data are taken independently
            if (aw_valid_i && !aw_ready_o && !aw_got) begin
                if (aw_wait == 2'd0)
                    aw_ready_o <= 1'b1;
                else
                    aw_wait <= aw_wait - 2'd1;
            end
            if (aw_valid_i && aw_ready_o) begin
                aw_ready_o <= 1'b0;
                aw_got     <= 1'b1;
                aw_wait    <= 2'($urandom_range(3, 0));
            end
            if (w_valid_i && !w_ready_o && !w_got) begin
                if (w_wait == 2'd0)
                    w_ready_o <= 1'b1;
                else
                    w_wait <= w_wait - 2'd1;
            end
            if (w_valid_i && w_ready_o) begin
                w_ready_o <= 1'b0;
                w_got     <= 1'b1;
                w_wait    <= 2'($urandom_range(3, 0));
            end
            if (aw_got && w_got && !b_valid_o) begin
                if (b_wait == 2'd0)
                    b_valid_o <= 1'b1;
                else
                    b_wait <= b_wait - 2'd1;
            end
            if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
                aw_got    <= 1'b0;
                w_got     <= 1'b0;
                b_wait    <= 2'($urandom_range(3, 0));
            end
        end
    end

endmodule

//--- tests/tb_dma_channel.sv
`timescale 1ns/10ps

module tb_dma_channel import dma_pkg::*; ();

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] SEED         = 32'h331875db;
    localparam data_t       PATTERN      = 32'h5a5a_0000;
    localparam addr_t       ERR_SRC      = 32'h0000_eff8; // two words below the error region
    localparam int          ERR_GOOD     = 2;
    localparam int          SINGLE_WORDS = 8;
    localparam int          CHAIN_WORDS  = 3 + 5 + 2;
    localparam int          ERR_WORDS    = 4;
    localparam int          STRESS_WORDS = 16;
    localparam int          WORD_CYCLES  = 40;   // worst case per word with stalls
    localparam int          SETUP_CYCLES = 200;
    localparam int          TOTAL_WORDS  = SINGLE_WORDS + CHAIN_WORDS + 2 * LINK_WORDS
                                           + ERR_WORDS + STRESS_WORDS;
    localparam int          WATCHDOG_CYCLES = TOTAL_WORDS * WORD_CYCLES + 5 * SETUP_CYCLES;

    logic       clk;
    logic       rst_n;
    logic       reg_wr;
    reg_idx_t   reg_idx;
    data_t      reg_wdata;
    data_t      reg_rdata;
    logic       irq;
    logic       ar_valid;
    addr_t      ar_addr;
    logic       ar_ready;
    logic       r_valid;
    data_t      r_data;
    logic [1:0] r_resp;
    logic       r_ready;
    logic       aw_valid;
    addr_t      aw_addr;
    logic       aw_ready;
    logic       w_valid;
    data_t      w_data;
    logic       w_ready;
    logic       b_valid;
    logic [1:0] b_resp;
    logic       b_ready;

    addr_t exp_addr_q[$];
    data_t exp_data_q[$];
    addr_t exp_rd_q[$];
    addr_t aw_q[$];
    data_t w_q[$];
    int    err_cnt = 0;
    int    chk_cnt = 0;
    int    wr_cnt  = 0;

    dma_channel u_dut (
        .clk(clk), .rst_n_i(rst_n),
        .reg_wr_i(reg_wr), .reg_idx_i(reg_idx), .reg_wdata_i(reg_wdata),
        .ar_ready_i(ar_ready), .r_valid_i(r_valid), .r_data_i(r_data), .r_resp_i(r_resp),
        .aw_ready_i(aw_ready), .w_ready_i(w_ready), .b_valid_i(b_valid), .b_resp_i(b_resp),
        .reg_rdata_o(reg_rdata), .irq_o(irq),
        .ar_valid_o(ar_valid), .ar_addr_o(ar_addr), .r_ready_o(r_ready),
        .aw_valid_o(aw_valid), .aw_addr_o(aw_addr),
        .w_valid_o(w_valid), .w_data_o(w_data), .b_ready_o(b_ready)
    );

    dma_mem_model u_mem (
        .clk(clk), .rst_n_i(rst_n),
        .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_ready_o(ar_ready),
        .r_valid_o(r_valid), .r_data_o(r_data), .r_resp_o(r_resp), .r_ready_i(r_ready),
        .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_valid_i(w_valid), .w_ready_o(w_ready),
        .b_valid_o(b_valid), .b_resp_o(b_resp), .b_ready_i(b_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input reg_idx_t idx, input data_t val);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_idx   <= idx;
        reg_wdata <= val;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic read_reg(input reg_idx_t idx, output data_t val);
        @(posedge clk);
        reg_idx <= idx;
        @(posedge clk);
        val = reg_rdata;
    endtask

    // reads go out one word at a time from base upward
    task automatic expect_reads(input addr_t base, input int n);
        for (int k = 0; k < n; k++)
            exp_rd_q.push_back(base + WORD_BYTES * addr_t'(k));
    endtask

    // every word k of a copy lands at dst + 4k with the source pattern
    task automatic expect_words(input addr_t src, input addr_t dst, input int n);
        expect_reads(src, n);
        for (int k = 0; k < n; k++) begin
            exp_addr_q.push_back(dst + WORD_BYTES * addr_t'(k));
            exp_data_q.push_back((src + WORD_BYTES * addr_t'(k)) ^ PATTERN);
        end
    endtask

    task automatic start_copy(input addr_t src, input addr_t dst, input int n,
                              input data_t link, input logic [1:0] irq_en);
        write_reg(REG_STATUS, 32'h3);
        write_reg(REG_INTREN, {30'd0, irq_en});
        write_reg(REG_SRCADDR, src);
        write_reg(REG_DESADDR, dst);
        write_reg(REG_XSIZE, data_t'(n));
        write_reg(REG_LINKADDR, link);
        write_reg(REG_CMD, 32'h1);
    endtask

    task automatic wait_status(input int max_cycles, output logic [1:0] st);
        int n;
        n  = 0;
        st = 2'b00;
        @(posedge clk);
        reg_idx <= REG_STATUS;
        while (st == 2'b00 && n < max_cycles) begin
            @(posedge clk);
            st = reg_rdata[1:0];
            n++;
        end
        if (st == 2'b00) begin
            err_cnt++;
            $display("no status bit set within %0d cycles at %0t", max_cycles, $time);
        end
    endtask

    task automatic finish_copy(input int words, input logic [1:0] exp_st, input logic exp_irq);
        logic [1:0] st;
        wait_status(words * WORD_CYCLES + SETUP_CYCLES, st);
        check_value("STATUS", 32'(st), 32'(exp_st));
        // status must not show up before the last expected write
        assert (exp_addr_q.size() == 0) else begin
            err_cnt++;
            $display("%0d expected writes still missing at completion, time %0t",
                     exp_addr_q.size(), $time);
        end
        assert (exp_rd_q.size() == 0) else begin
            err_cnt++;
            $display("%0d expected reads still missing at completion, time %0t",
                     exp_rd_q.size(), $time);
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_rd_q.delete();
        repeat (3) begin
            @(posedge clk);
            check_value("irq_o", 32'(irq), 32'(exp_irq));
        end
    endtask

    task automatic load_descriptors();
        u_mem.load_word(32'h8000, 32'h3100);
        u_mem.load_word(32'h8004, 32'h4100);
        u_mem.load_word(32'h8008, 32'd5);
        u_mem.load_word(32'h800c, 32'h8011);  // next hop with link enabled
        u_mem.load_word(32'h8010, 32'h3200);
        u_mem.load_word(32'h8014, 32'h4200);
        u_mem.load_word(32'h8018, 32'd2);
        u_mem.load_word(32'h801c, 32'h0);     // end of chain
    endtask

    // every accepted read address is the next one expected
    always @(posedge clk) begin : read_check
        if (rst_n && ar_valid && ar_ready) begin
            if (exp_rd_q.size() == 0) begin
                err_cnt++;
                $display("unexpected read from %h at %0t", ar_addr, $time);
            end else begin
                check_value("ar_addr_o", ar_addr, exp_rd_q.pop_front());
            end
        end
    end

    // pairs aw and w handshakes in order and compares with the expected list
    always @(posedge clk) begin : write_check
        addr_t a;
        data_t d;
        if (rst_n) begin
            if (aw_valid && aw_ready)
                aw_q.push_back(aw_addr);
            if (w_valid && w_ready)
                w_q.push_back(w_data);
            if (aw_q.size() > 0 && w_q.size() > 0) begin
                a = aw_q.pop_front();
                d = w_q.pop_front();
                if (exp_addr_q.size() == 0) begin
                    err_cnt++;
                    $display("unexpected write of %h to %h at %0t", d, a, $time);
                end else begin
                    check_value("aw_addr_o", a, exp_addr_q.pop_front());
                    check_value("w_data_o", d, exp_data_q.pop_front());
                    wr_cnt++;
                end
            end
        end
    end

    a_aw_with_w: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(aw_valid) |-> w_valid)
        else begin
            err_cnt++;
            $display("aw_valid_o rose without w_valid_o at %0t", $time);
        end

    initial begin : watchdog
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        data_t rd;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_idx   = REG_CMD;
        reg_wdata = '0;
        load_descriptors();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("ar_valid_o", 32'(ar_valid), 32'd0);
        check_value("aw_valid_o", 32'(aw_valid), 32'd0);
        check_value("w_valid_o", 32'(w_valid), 32'd0);
        check_value("r_ready_o", 32'(r_ready), 32'd0);
        check_value("b_ready_o", 32'(b_ready), 32'd0);
        check_value("irq_o", 32'(irq), 32'd0);

        // single copy with the done interrupt enabled
        expect_words(32'h1000, 32'h2000, SINGLE_WORDS);
        start_copy(32'h1000, 32'h2000, SINGLE_WORDS, 32'h0, 2'b01);
        finish_copy(SINGLE_WORDS, 2'b01, 1'b1);

        // w1c on done and enable cleared by hardware
        read_reg(REG_CMD, rd);
        check_value("CMD", rd, 32'd0);
        write_reg(REG_STATUS, 32'h1);
        read_reg(REG_STATUS, rd);
        check_value("STATUS", rd, 32'd0);
        check_value("irq_o", 32'(irq), 32'd0);

        // first copy links to two descriptors in memory
        expect_words(32'h3000, 32'h4000, 3);
        expect_reads(32'h8000, LINK_WORDS);
        expect_words(32'h3100, 32'h4100, 5);
        expect_reads(32'h8010, LINK_WORDS);
        expect_words(32'h3200, 32'h4200, 2);
        start_copy(32'h3000, 32'h4000, 3, 32'h8001, 2'b01);
        finish_copy(CHAIN_WORDS + 2 * LINK_WORDS, 2'b01, 1'b1);

        // source runs into the error region
        expect_words(ERR_SRC, 32'h7000, ERR_GOOD);
        expect_reads(ERR_SRC + WORD_BYTES * addr_t'(ERR_GOOD), 1);
        start_copy(ERR_SRC, 32'h7000, ERR_WORDS, 32'h0, 2'b10);
        finish_copy(ERR_WORDS, 2'b10, 1'b1);
        read_reg(REG_CMD, rd);
        check_value("CMD", rd, 32'd0);

        // longer copy with interrupts masked
        expect_words(32'h5000, 32'h6000, STRESS_WORDS);
        start_copy(32'h5000, 32'h6000, STRESS_WORDS, 32'h0, 2'b00);
        finish_copy(STRESS_WORDS, 2'b01, 1'b0);

        repeat (5) @(posedge clk);
        $display("checks %0d, writes %0d, errors %0d", chk_cnt, wr_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
src/dma_pkg.sv
src/dma_chan_regs.sv
src/dma_link_fetch.sv
src/dma_data_mover.sv
src/dma_rd_arbiter.sv
src/dma_channel.sv
tests/dma_mem_model.sv
tests/tb_dma_channel.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_channel \
    -f files.f -o sim_dma_channel &&
    ./obj_dir/sim_dma_channel | tee sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "pass line found in sim.log" ||
    { echo "no pass line in sim.log"; exit 1; }
